// ==== src/hbm_cfg.svh ====
`ifndef HBM_CFG_SVH
`define HBM_CFG_SVH

////////////////////////////////////////
// engines and channels
////////////////////////////////////////

// read engines, one hbm channel each
`define ENGINE_NUM          4

////////////////////////////////////////
// widths
////////////////////////////////////////

`define DATA_WIDTH          256     // hbm and dma beat
`define BYTES_PER_BEAT      32
`define PARAM_WIDTH         512     // host parameter word
`define HBM_ADDR_WIDTH      33      // 8 GB byte space
`define CHAN_OFFSET_BITS    28      // 256 MB per channel

////////////////////////////////////////
// memory map and bursts
////////////////////////////////////////

// b data lands in one fixed channel
`define B_DATA_CHANNEL      2
`define HBM_B_OFFSET        28'h800_0000    // upper half of that channel
`define BURST_LEN           8               // beats per read burst

`endif

// ==== src/hbm_pkg.sv ====
`include "hbm_cfg.svh"

package hbm_pkg;

    ////////////////////////////////////////
    // host parameters
    ////////////////////////////////////////

    // first field sits highest in the packed vector
    typedef struct packed {
        logic [63:0] addr_a;            // a matrix base, host side
        logic [63:0] addr_b;            // b vector base, host side
        logic [31:0] number_of_epochs;
        logic [31:0] dimension;
        logic [31:0] number_of_samples;
        logic [31:0] number_of_bits;    // bit planes per epoch
        logic [31:0] array_length;      // byte stride between planes
    } sgd_params_t;

    ////////////////////////////////////////
    // dma side
    ////////////////////////////////////////

    typedef struct packed {
        logic [63:0] address;
        logic [31:0] length;            // bytes
    } dma_cmd_t;

    // one data word, dma data, hbm read data and lanes alike
    typedef logic [`DATA_WIDTH-1:0] hbm_beat_t;

    ////////////////////////////////////////
    // hbm side
    ////////////////////////////////////////

    // single-beat write
    typedef struct packed {
        logic [`HBM_ADDR_WIDTH-1:0] addr;   // byte address
        logic [`DATA_WIDTH-1:0]     data;
    } hbm_wr_t;

    // burst read request
    typedef struct packed {
        logic [`HBM_ADDR_WIDTH-1:0] addr;   // byte address
        logic [7:0]                 len;    // beats minus one, axi style
    } hbm_rd_req_t;

endpackage

// ==== src/sgd_param_regs.sv ====
`timescale 1ns/100ps
`include "hbm_cfg.svh"

module sgd_param_regs import hbm_pkg::*; (
    input  logic                    hbm_clk,
    input  logic                    hbm_rstn,

    // host parameter strobe
    input  logic                    param_valid,
    input  logic [`PARAM_WIDTH-1:0] param_data,

    // held configuration
    output sgd_params_t             params,
    output logic [31:0]             data_b_length,  // bytes of b data
    output logic                    load_start
);

    ////////////////////////////////////////
    // field capture
    ////////////////////////////////////////

    // word layout from the host driver
    // 191:128 model addr, 223:192 batch, 255:224 step, 415:384 a length,
    // 479:448 channel select, none of them needed here
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            params        <= '0;
            data_b_length <= 32'd0;
        end else if (param_valid) begin
            params.addr_a            <= param_data[63:0];
            params.addr_b            <= param_data[127:64];
            params.number_of_epochs  <= param_data[287:256];
            params.dimension         <= param_data[319:288];
            params.number_of_samples <= param_data[351:320];
            params.number_of_bits    <= param_data[383:352];
            params.array_length      <= param_data[447:416];
            // one 32-bit label per sample
            data_b_length            <= param_data[351:320] << 2;
        end
    end

    ////////////////////////////////////////
    // start strobe
    ////////////////////////////////////////

    // lines up with the freshly captured fields
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            load_start <= 1'b0;
        end else begin
            load_start <= param_valid;  // one cycle, follows the host strobe
        end
    end

endmodule

// ==== src/hbm_b_loader.sv ====
`timescale 1ns/100ps
`include "hbm_cfg.svh"

module hbm_b_loader import hbm_pkg::*; (
    input  logic        hbm_clk,
    input  logic        hbm_rstn,

    // from the parameter block
    input  logic        load_start,
    input  logic [63:0] addr_b,
    input  logic [31:0] data_b_length,

    // dma read command and returned data
    output logic        dma_rd_cmd_valid,
    output dma_cmd_t    dma_rd_cmd,
    input  logic        dma_rd_data_valid,
    input  hbm_beat_t   dma_rd_data,

    // hbm writes into the b channel
    output logic        hbm_wr_valid,
    output hbm_wr_t     hbm_wr,
    output logic        write_done
);

    localparam int BEAT_SHIFT = $clog2(`BYTES_PER_BEAT);

    // first byte of the b region
    localparam logic [`HBM_ADDR_WIDTH-1:0] B_BASE =
        (`HBM_ADDR_WIDTH'(`B_DATA_CHANNEL) << `CHAN_OFFSET_BITS)
        + `HBM_ADDR_WIDTH'(`HBM_B_OFFSET);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DATA,
        DONE
    } state_t;

    state_t      state;
    logic [31:0] beat_total;    // latched at start
    logic [31:0] beat_cnt;      // beats written so far
    logic [31:0] start_beats;
    logic        beat_accept;
    logic        last_beat;

    assign start_beats = data_b_length >> BEAT_SHIFT;     // partial beat dropped
    assign beat_accept = (state == WAIT_DATA) && dma_rd_data_valid;
    assign last_beat   = beat_accept && (beat_cnt == beat_total - 32'd1);

    ////////////////////////////////////////
    // control fsm
    ////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            state            <= IDLE;
            dma_rd_cmd_valid <= 1'b0;
            hbm_wr_valid     <= 1'b0;
            write_done       <= 1'b0;
            beat_total       <= 32'd0;
            beat_cnt         <= 32'd0;
        end else begin
            dma_rd_cmd_valid <= 1'b0;
            write_done       <= 1'b0;
            hbm_wr_valid     <= beat_accept;   // one cycle behind the dma beat
            case (state)
                IDLE: begin
                    // new loads only from here
                    if (load_start) begin
                        beat_total <= start_beats;
                        beat_cnt   <= 32'd0;
                        if (start_beats == 32'd0) begin
                            write_done <= 1'b1;       // nothing to fetch
                        end else begin
                            dma_rd_cmd_valid <= 1'b1;
                            state            <= WAIT_DATA;
                        end
                    end
                end
                WAIT_DATA: begin
                    if (beat_accept) begin
                        beat_cnt <= beat_cnt + 32'd1;
                        if (last_beat) begin
                            state <= DONE;          // last write goes out now
                        end
                    end
                end
                DONE: begin
                    write_done <= 1'b1;   // one cycle after the last write
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // command and write payload
    ////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (load_start && (state == IDLE)) begin
            dma_rd_cmd.address <= addr_b;
            dma_rd_cmd.length  <= data_b_length;
        end
        if (beat_accept) begin
            hbm_wr.addr <= B_BASE + (`HBM_ADDR_WIDTH'(beat_cnt) << BEAT_SHIFT);
            hbm_wr.data <= dma_rd_data;     // passes unchanged
        end
    end

endmodule

// ==== src/hbm_read_engine.sv ====
`timescale 1ns/100ps
`include "hbm_cfg.svh"

module hbm_read_engine import hbm_pkg::*; #(
    parameter int ENGINE_ID = 0     // also the hbm channel
) (
    input  logic        hbm_clk,
    input  logic        hbm_rstn,

    input  logic        start,      // b data is in place
    input  logic [31:0] number_of_epochs,
    input  logic [31:0] number_of_bits,
    input  logic [31:0] array_length,

    // burst read requests, one per cycle
    output logic        rd_req_valid,
    output hbm_rd_req_t rd_req
);

    // channel base address
    localparam logic [`HBM_ADDR_WIDTH-1:0] CHAN_BASE =
        `HBM_ADDR_WIDTH'(ENGINE_ID) << `CHAN_OFFSET_BITS;

    logic                       running;
    logic [31:0]                epoch_cnt;
    logic [31:0]                bit_cnt;    // bit plane within the epoch
    logic [`HBM_ADDR_WIDTH-1:0] addr_off;   // bit_cnt times stride
    logic                       bit_wrap;
    logic                       epoch_wrap;

    assign bit_wrap   = (bit_cnt == number_of_bits - 32'd1);
    assign epoch_wrap = (epoch_cnt == number_of_epochs - 32'd1);

    ////////////////////////////////////////
    // epoch and bit-plane walk
    ////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            running   <= 1'b0;
            epoch_cnt <= 32'd0;
            bit_cnt   <= 32'd0;
            addr_off  <= '0;
        end else if (!running) begin
            // empty sweep never starts
            if (start && (number_of_epochs != 32'd0) && (number_of_bits != 32'd0)) begin
                running <= 1'b1;
            end
            epoch_cnt <= 32'd0;
            bit_cnt   <= 32'd0;
            addr_off  <= '0;
        end else if (bit_wrap) begin
            // back to plane 0, next epoch
            bit_cnt   <= 32'd0;
            addr_off  <= '0;
            epoch_cnt <= epoch_cnt + 32'd1;
            if (epoch_wrap) begin
                running <= 1'b0;    // that was the final request
            end
        end else begin
            bit_cnt  <= bit_cnt + 32'd1;
            addr_off <= addr_off + `HBM_ADDR_WIDTH'(array_length);
        end
    end

    ////////////////////////////////////////
    // request out
    ////////////////////////////////////////

    assign rd_req_valid = running;                  // no gaps while running
    assign rd_req.addr  = CHAN_BASE + addr_off;
    assign rd_req.len   = 8'(`BURST_LEN - 1);        // fixed burst

endmodule

// ==== src/hbm_dispatch.sv ====
`timescale 1ns/100ps
`include "hbm_cfg.svh"

module hbm_dispatch import hbm_pkg::*; (
    input  logic                         hbm_clk,
    input  logic                         hbm_rstn,

    input  logic                         start,     // read phase begins
    input  logic [31:0]                  number_of_epochs,
    input  logic [31:0]                  number_of_bits,

    // hbm read responses, one port per engine
    input  logic      [`ENGINE_NUM-1:0]  rsp_valid,
    input  hbm_beat_t [`ENGINE_NUM-1:0]  rsp,

    // per-engine lanes
    output logic      [`ENGINE_NUM-1:0]  lane_valid,
    output hbm_beat_t [`ENGINE_NUM-1:0]  lane_data,
    output logic                         mem_op_done
);

    logic [31:0]                   beats_expected;     // per engine
    logic                          active;
    logic [`ENGINE_NUM-1:0][31:0]  beat_cnt;
    logic [`ENGINE_NUM-1:0][31:0]  beat_cnt_next;
    logic [`ENGINE_NUM-1:0]        engine_full;

    // one burst per request
    assign beats_expected = number_of_epochs * number_of_bits * 32'(`BURST_LEN);

    ////////////////////////////////////////
    // beat counting
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `ENGINE_NUM; i++) begin
            beat_cnt_next[i] = beat_cnt[i];
            // counter stops at the target, stray beats ignored
            if (rsp_valid[i] && (beat_cnt[i] != beats_expected)) begin
                beat_cnt_next[i] = beat_cnt[i] + 32'd1;
            end
            engine_full[i] = (beat_cnt_next[i] == beats_expected);
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            active      <= 1'b0;
            mem_op_done <= 1'b0;
            beat_cnt    <= '0;
            lane_valid  <= '0;
        end else begin
            lane_valid  <= rsp_valid;   // lanes track responses one cycle later
            mem_op_done <= 1'b0;
            if (!active) begin
                beat_cnt <= '0;
                if (start) begin
                    if (beats_expected == 32'd0) begin
                        mem_op_done <= 1'b1;    // nothing to wait for
                    end else begin
                        active <= 1'b1;
                    end
                end
            end else begin
                beat_cnt <= beat_cnt_next;
                // last engine filled this cycle
                if (&engine_full) begin
                    mem_op_done <= 1'b1;
                    active      <= 1'b0;
                end
            end
        end
    end

    // lane payload, no reset
    always_ff @(posedge hbm_clk) begin
        lane_data <= rsp;
    end

endmodule

// ==== src/hbm_interface.sv ====
`timescale 1ns/100ps
`include "hbm_cfg.svh"

module hbm_interface import hbm_pkg::*; (
    input  logic                          hbm_clk,
    input  logic                          hbm_rstn,

    // host parameter word
    input  logic                          param_valid,
    input  logic [`PARAM_WIDTH-1:0]       param_data,

    // dma read path
    output logic                          dma_rd_cmd_valid,
    output dma_cmd_t                      dma_rd_cmd,
    input  logic                          dma_rd_data_valid,
    input  hbm_beat_t                     dma_rd_data,

    // b data writes, channel B_DATA_CHANNEL
    output logic                          hbm_wr_valid,
    output hbm_wr_t                       hbm_wr,

    // per-channel reads
    output logic        [`ENGINE_NUM-1:0] hbm_rd_req_valid,
    output hbm_rd_req_t [`ENGINE_NUM-1:0] hbm_rd_req,
    input  logic        [`ENGINE_NUM-1:0] hbm_rd_rsp_valid,
    input  hbm_beat_t   [`ENGINE_NUM-1:0] hbm_rd_rsp,

    // dispatched lanes
    output logic        [`ENGINE_NUM-1:0] lane_valid,
    output hbm_beat_t   [`ENGINE_NUM-1:0] lane_data,
    output logic                          mem_op_done
);

    sgd_params_t params;
    logic [31:0] data_b_length;
    logic        load_start;
    logic        write_done;    // kicks off the read phase

    ////////////////////////////////////////
    // configuration
    ////////////////////////////////////////

    sgd_param_regs u_param_regs (
        .hbm_clk       (hbm_clk),
        .hbm_rstn      (hbm_rstn),
        .param_valid   (param_valid),
        .param_data    (param_data),
        .params        (params),
        .data_b_length (data_b_length),
        .load_start    (load_start)
    );

    ////////////////////////////////////////
    // b data load
    ////////////////////////////////////////

    hbm_b_loader u_b_loader (
        .hbm_clk           (hbm_clk),
        .hbm_rstn          (hbm_rstn),
        .load_start        (load_start),
        .addr_b            (params.addr_b),
        .data_b_length     (data_b_length),
        .dma_rd_cmd_valid  (dma_rd_cmd_valid),
        .dma_rd_cmd        (dma_rd_cmd),
        .dma_rd_data_valid (dma_rd_data_valid),
        .dma_rd_data       (dma_rd_data),
        .hbm_wr_valid      (hbm_wr_valid),
        .hbm_wr            (hbm_wr),
        .write_done        (write_done)
    );

    ////////////////////////////////////////
    // read engines, one per channel
    ////////////////////////////////////////

    for (genvar g = 0; g < `ENGINE_NUM; g++) begin : g_engine
        hbm_read_engine #(
            .ENGINE_ID (g)
        ) u_read_engine (
            .hbm_clk          (hbm_clk),
            .hbm_rstn         (hbm_rstn),
            .start            (write_done),
            .number_of_epochs (params.number_of_epochs),
            .number_of_bits   (params.number_of_bits),
            .array_length     (params.array_length),
            .rd_req_valid     (hbm_rd_req_valid[g]),
            .rd_req           (hbm_rd_req[g])
        );
    end

    // response fan-in and completion
    hbm_dispatch u_dispatch (
        .hbm_clk          (hbm_clk),
        .hbm_rstn         (hbm_rstn),
        .start            (write_done),
        .number_of_epochs (params.number_of_epochs),
        .number_of_bits   (params.number_of_bits),
        .rsp_valid        (hbm_rd_rsp_valid),
        .rsp              (hbm_rd_rsp),
        .lane_valid       (lane_valid),
        .lane_data        (lane_data),
        .mem_op_done      (mem_op_done)
    );

endmodule

// ==== testbench/tb_hbm_interface.sv ====
`timescale 1ns/100ps
`include "hbm_cfg.svh"

module tb_hbm_interface import hbm_pkg::*; ();

    localparam int CMD_TIMEOUT  = 20;     // parameter word to dma command
    localparam int DONE_TIMEOUT = 4000;   // whole read phase of one set

    // b region base from channel number and in-channel offset
    localparam logic [`HBM_ADDR_WIDTH-1:0] B_BASE =
        (`HBM_ADDR_WIDTH'(`B_DATA_CHANNEL) << `CHAN_OFFSET_BITS)
        + `HBM_ADDR_WIDTH'(`HBM_B_OFFSET);

    logic                             hbm_clk;
    logic                             hbm_rstn;
    logic                             param_valid;
    logic [`PARAM_WIDTH-1:0]          param_data;
    logic                             dma_rd_cmd_valid;
    dma_cmd_t                         dma_rd_cmd;
    logic                             dma_rd_data_valid;
    hbm_beat_t                        dma_rd_data;
    logic                             hbm_wr_valid;
    hbm_wr_t                          hbm_wr;
    logic        [`ENGINE_NUM-1:0]    hbm_rd_req_valid;
    hbm_rd_req_t [`ENGINE_NUM-1:0]    hbm_rd_req;
    logic        [`ENGINE_NUM-1:0]    hbm_rd_rsp_valid;
    hbm_beat_t   [`ENGINE_NUM-1:0]    hbm_rd_rsp;
    logic        [`ENGINE_NUM-1:0]    lane_valid;
    hbm_beat_t   [`ENGINE_NUM-1:0]    lane_data;
    logic                             mem_op_done;

    int  seed = 98124;
    int  cyc = 0;               // cycle number seen at the falling edge
    bit  monitor_on = 1'b0;

    // current parameter set from the vector file
    logic [63:0] v_addr_b;
    int          v_samples;
    int          v_bits;
    int          v_epochs;
    int          v_array_len;
    int          v_beats = 0;   // expected dma beats
    int          v_reqs = 0;    // expected requests per engine

    // scoreboard state reset per parameter set
    int          param_cyc = -1000;
    int          last_wr_cyc;
    int          full_cyc;      // cycle of the last response beat overall
    int          cmd_cnt;
    int          wr_cnt;
    int          done_cnt;
    int          req_cnt  [`ENGINE_NUM];
    int          rsp_cnt  [`ENGINE_NUM];
    int          lane_cnt [`ENGINE_NUM];
    logic [`ENGINE_NUM-1:0] prev_rsp_valid = '0;
    hbm_beat_t   prev_rsp [`ENGINE_NUM];
    hbm_beat_t   dma_beat_q [$];    // dma beats waiting for their write
    int          dma_cyc_q [$];
    hbm_beat_t   rsp_q [`ENGINE_NUM][$];    // pending beats of the hbm model

    hbm_interface UUT (
        .hbm_clk           (hbm_clk),
        .hbm_rstn          (hbm_rstn),
        .param_valid       (param_valid),
        .param_data        (param_data),
        .dma_rd_cmd_valid  (dma_rd_cmd_valid),
        .dma_rd_cmd        (dma_rd_cmd),
        .dma_rd_data_valid (dma_rd_data_valid),
        .dma_rd_data       (dma_rd_data),
        .hbm_wr_valid      (hbm_wr_valid),
        .hbm_wr            (hbm_wr),
        .hbm_rd_req_valid  (hbm_rd_req_valid),
        .hbm_rd_req        (hbm_rd_req),
        .hbm_rd_rsp_valid  (hbm_rd_rsp_valid),
        .hbm_rd_rsp        (hbm_rd_rsp),
        .lane_valid        (lane_valid),
        .lane_data         (lane_data),
        .mem_op_done       (mem_op_done)
    );

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0d ns: %s is %0h, expected %0h",
                                $time, name, actual, expected));
        end
    endtask

    // read phase opens two cycles after the last write,
    // or three after the parameter word when nothing is loaded
    function automatic int read_start_cycle();
        return (v_beats == 0) ? param_cyc + 3 : last_wr_cyc + 2;
    endfunction

    ////////////////////////////////////////
    // per-cycle checks
    ////////////////////////////////////////

    task automatic check_dma_side();
        hbm_beat_t                  beat;
        int                         beat_cyc;
        logic [`HBM_ADDR_WIDTH-1:0] exp_addr;
        if (param_valid) begin
            param_cyc = cyc;
        end
        if (dma_rd_cmd_valid) begin
            cmd_cnt++;
            if (v_beats == 0 || cmd_cnt > 1) begin
                abort_run("DMA read command issued where none was expected");
            end else begin
                check_value("dma_rd_cmd_valid cycle", 256'(cyc), 256'(param_cyc + 2));
                check_value("dma_rd_cmd.address", 256'(dma_rd_cmd.address), 256'(v_addr_b));
                check_value("dma_rd_cmd.length", 256'(dma_rd_cmd.length), 256'(v_samples * 4));
            end
        end
        // match writes before this cycle's beat is queued below
        if (hbm_wr_valid) begin
            if (dma_beat_q.size() == 0) begin
                abort_run("HBM write came out with no DMA beat before it");
            end else begin
                beat     = dma_beat_q.pop_front();
                beat_cyc = dma_cyc_q.pop_front();
                exp_addr = B_BASE + `HBM_ADDR_WIDTH'(wr_cnt) * `HBM_ADDR_WIDTH'(`BYTES_PER_BEAT);
                check_value("hbm_wr_valid cycle", 256'(cyc), 256'(beat_cyc + 1));
                check_value("hbm_wr.addr", 256'(hbm_wr.addr), 256'(exp_addr));
                check_value("hbm_wr.data", hbm_wr.data, beat);
                wr_cnt++;
                last_wr_cyc = cyc;
            end
        end
        if (dma_rd_data_valid) begin
            dma_beat_q.push_back(dma_rd_data);
            dma_cyc_q.push_back(cyc);
        end
    endtask

    task automatic check_requests();
        logic [`HBM_ADDR_WIDTH-1:0] exp_addr;
        for (int i = 0; i < `ENGINE_NUM; i++) begin
            if (hbm_rd_req_valid[i]) begin
                if (req_cnt[i] >= v_reqs) begin
                    abort_run($sformatf("engine %0d issued more than %0d requests", i, v_reqs));
                end else begin
                    // stride walk restarts every epoch
                    exp_addr = (`HBM_ADDR_WIDTH'(i) << `CHAN_OFFSET_BITS)
                             + `HBM_ADDR_WIDTH'(req_cnt[i] % v_bits)
                             * `HBM_ADDR_WIDTH'(v_array_len);
                    check_value($sformatf("hbm_rd_req_valid[%0d] cycle", i), 256'(cyc),
                                256'(read_start_cycle() + req_cnt[i]));
                    check_value($sformatf("hbm_rd_req[%0d].addr", i),
                                256'(hbm_rd_req[i].addr), 256'(exp_addr));
                    check_value($sformatf("hbm_rd_req[%0d].len", i),
                                256'(hbm_rd_req[i].len), 256'(`BURST_LEN - 1));
                    for (int b = 0; b < `BURST_LEN; b++) begin
                        rsp_q[i].push_back(hbm_beat_t'(exp_addr) + hbm_beat_t'(b)); // addr + index
                    end
                    req_cnt[i]++;
                end
            end
        end
    endtask

    task automatic check_lanes();
        bit all_full;
        all_full = (v_reqs > 0);
        for (int i = 0; i < `ENGINE_NUM; i++) begin
            check_value($sformatf("lane_valid[%0d]", i), 256'(lane_valid[i]),
                        256'(prev_rsp_valid[i]));
            if (prev_rsp_valid[i]) begin
                check_value($sformatf("lane_data[%0d]", i), lane_data[i], prev_rsp[i]);
                lane_cnt[i]++;
            end
            prev_rsp_valid[i] = hbm_rd_rsp_valid[i];   // what the model drove this cycle
            prev_rsp[i]       = hbm_rd_rsp[i];
            if (hbm_rd_rsp_valid[i]) begin
                rsp_cnt[i]++;
            end
            if (rsp_cnt[i] != v_reqs * `BURST_LEN) begin
                all_full = 1'b0;
            end
        end
        if (all_full && full_cyc < 0) begin
            full_cyc = cyc;
        end
    endtask

    task automatic check_done();
        if (mem_op_done) begin
            done_cnt++;
            if (done_cnt > 1) begin
                abort_run("mem_op_done pulsed more than once for one parameter set");
            end else if (v_reqs == 0) begin
                check_value("mem_op_done cycle", 256'(cyc), 256'(read_start_cycle()));
            end else begin
                check_value("mem_op_done cycle", 256'(cyc), 256'(full_cyc + 1));
            end
        end
    endtask

    ////////////////////////////////////////
    // one parameter set with the dma model inline
    ////////////////////////////////////////

    task automatic run_vector();
        logic [`PARAM_WIDTH-1:0] word;
        hbm_beat_t               beat;
        int                      waited;
        int                      gap;
        cmd_cnt     = 0;
        wr_cnt      = 0;
        done_cnt    = 0;
        last_wr_cyc = -1;
        full_cyc    = -1;
        for (int i = 0; i < `ENGINE_NUM; i++) begin
            req_cnt[i]  = 0;
            rsp_cnt[i]  = 0;
            lane_cnt[i] = 0;
        end
        // random filler that the unused fields must not pass on
        for (int w = 0; w < `PARAM_WIDTH / 32; w++) begin
            word[w*32 +: 32] = $random(seed);
        end
        word[127:64]  = v_addr_b;
        word[287:256] = v_epochs;
        word[351:320] = v_samples;
        word[383:352] = v_bits;
        word[447:416] = v_array_len;
        @(posedge hbm_clk);
        param_valid <= 1'b1;
        param_data  <= word;
        @(posedge hbm_clk);
        param_valid <= 1'b0;
        if (v_beats > 0) begin
            waited = 0;
            while (cmd_cnt == 0 && waited < CMD_TIMEOUT) begin
                @(posedge hbm_clk);
                waited++;
            end
            if (cmd_cnt == 0) begin
                abort_run("no DMA read command followed the parameter word");
            end
            gap = $random(seed) & 3;     // dma latency 0..3
            repeat (gap) @(posedge hbm_clk);
            for (int b = 0; b < v_beats; b++) begin
                for (int w = 0; w < 8; w++) begin
                    beat[w*32 +: 32] = $random(seed);
                end
                @(posedge hbm_clk);
                dma_rd_data_valid <= 1'b1;
                dma_rd_data       <= beat;
            end
            @(posedge hbm_clk);
            dma_rd_data_valid <= 1'b0;
        end
        waited = 0;
        while (done_cnt == 0 && waited < DONE_TIMEOUT) begin
            @(posedge hbm_clk);
            waited++;
        end
        if (done_cnt == 0) begin
            abort_run("mem_op_done never came at the end of the read phase");
        end
        repeat (6) @(posedge hbm_clk);     // room for late or repeated strobes
        check_value("HBM write count", 256'(wr_cnt), 256'(v_beats));
        for (int i = 0; i < `ENGINE_NUM; i++) begin
            check_value($sformatf("engine %0d request count", i), 256'(req_cnt[i]),
                        256'(v_reqs));
            check_value($sformatf("lane %0d beat count", i), 256'(lane_cnt[i]),
                        256'(v_reqs * `BURST_LEN));
        end
    endtask

    ////////////////////////////////////////
    // clock, models, monitor
    ////////////////////////////////////////

    initial begin
        hbm_clk = 1'b0;
        forever #10 hbm_clk = ~hbm_clk;     // 20 ns
    end

    always @(posedge hbm_clk) cyc <= cyc + 1;

    // hbm model with one beat per cycle and engine and a fixed stall pattern
    initial begin
        hbm_rd_rsp_valid <= '0;
        hbm_rd_rsp       <= '0;
        forever begin
            @(posedge hbm_clk);
            for (int i = 0; i < `ENGINE_NUM; i++) begin
                if (rsp_q[i].size() > 0 && ((cyc + i) % 5) != 4) begin
                    hbm_rd_rsp_valid[i] <= 1'b1;
                    hbm_rd_rsp[i]       <= rsp_q[i].pop_front();
                end else begin
                    hbm_rd_rsp_valid[i] <= 1'b0;
                end
            end
        end
    end

    // sample mid-cycle when everything has settled
    initial begin
        forever begin
            @(negedge hbm_clk);
            if (monitor_on) begin
                check_dma_side();
                check_requests();
                check_lanes();
                check_done();
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int    fd;
        int    n;
        int    vec_cnt;
        string line;
        vec_cnt = 0;
        hbm_rstn          <= 1'b0;
        param_valid       <= 1'b0;
        param_data        <= '0;
        dma_rd_data_valid <= 1'b0;
        dma_rd_data       <= '0;
        repeat (2) @(posedge hbm_clk);
        hbm_rstn <= 1'b1;
        // quiet outputs before any parameter word
        repeat (6) begin
            @(negedge hbm_clk);
            check_value("dma_rd_cmd_valid", 256'(dma_rd_cmd_valid), 256'(0));
            check_value("hbm_wr_valid", 256'(hbm_wr_valid), 256'(0));
            check_value("hbm_rd_req_valid", 256'(hbm_rd_req_valid), 256'(0));
            check_value("lane_valid", 256'(lane_valid), 256'(0));
            check_value("mem_op_done", 256'(mem_op_done), 256'(0));
        end
        @(posedge hbm_clk);
        monitor_on = 1'b1;
        fd = $fopen("testbench/hbm_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open testbench/hbm_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %d %d %d %d %d %d", v_addr_b, v_samples, v_bits,
                            v_epochs, v_array_len, v_beats, v_reqs);
                if (n != 7) begin
                    abort_run($sformatf("vector line could not be parsed: %s", line));
                end
                run_vector();
                vec_cnt++;
            end
        end
        $fclose(fd);
        if (vec_cnt == 0) begin
            abort_run("vector file held no parameter sets");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== build.f ====
+incdir+src
src/hbm_pkg.sv
src/sgd_param_regs.sv
src/hbm_b_loader.sv
src/hbm_read_engine.sv
src/hbm_dispatch.sv
src/hbm_interface.sv
testbench/tb_hbm_interface.sv

// ==== Makefile ====
# verilator build and run of the hbm interface testbench

TOP  := tb_hbm_interface
SRCS := $(filter-out +%,$(shell cat build.f))

.PHONY: all run clean

all: obj_dir/V$(TOP)

# rebuilt only when a source, the config header or the file list changes
obj_dir/V$(TOP): build.f $(SRCS) src/hbm_cfg.svh
	verilator --binary --timing -f build.f --top-module $(TOP)

# exit status of the simulator is the verdict
run: obj_dir/V$(TOP)
	obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== testbench/hbm_vectors.txt ====
# addr_b(hex) number_of_samples number_of_bits number_of_epochs array_length
#   then expected dma beats (samples*4/32, rounded down) and requests per engine (epochs*bits)
0000000123450000 16 4 2 1024 2 8
00000000abcd0040 64 3 1 4096 8 3
00000000dead0000 0 2 3 512 0 6
0000007f00001000 20 1 1 64 2 1
0000000000200000 8 0 5 256 1 0
0000001000000000 40 8 1 1048576 5 8
0000000000000000 0 4 0 128 0 0
00000002000a0000 256 4 3 2048 32 12
00000000cafe0000 12 2 2 32 1 4
